// ==== files.f ====
src/sysctl_pkg.sv
src/sysctl_bus_fsm.sv
src/sysctl_tick_timer.sv
src/sysctl_reset_ctrl.sv
src/sysctl_regs.sv
src/sysctl_top.sv
testbench/tb_sysctl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the sysctl testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tb_sysctl -f files.f -o tb_sysctl_sim; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/tb_sysctl_sim; then
	echo "simulation reported failure"
	exit 1
fi

exit 0

// ==== src/sysctl_bus_fsm.sv ====
`timescale 1ns/1ps

module sysctl_bus_fsm #(
	parameter int BUS_TIMEOUT = 16
) (
	input  logic                         node_clk,
	input  logic                         rst,
	input  logic                         req_i,
	input  logic                         we_i,
	input  logic [sysctl_pkg::ADR_W-1:0] adr_i,
	output sysctl_pkg::reg_sel_e         reg_sel_o,
	output logic                         wr_stb_o,
	output logic                         rd_stb_o,
	output logic                         ack_o,
	output logic                         err_o
);

localparam int TO_W = $clog2(BUS_TIMEOUT + 1);

sysctl_pkg::bus_state_e state;
sysctl_pkg::bus_state_e state_nxt;
logic [TO_W-1:0] to_cnt;	// cycles spent in BUS_WAIT
logic io_hit;
logic [11:0] page;
logic take;	// request accepted this cycle

// ------------------------------------------------------------
// address decode
// ------------------------------------------------------------
assign io_hit = adr_i[sysctl_pkg::ADR_W-1 -: 12] == sysctl_pkg::IO_REGION;
assign page = adr_i[19:8];

always_comb begin
	reg_sel_o = sysctl_pkg::REG_NONE;	// anything not listed times out
	if (io_hit) begin
		if (page == sysctl_pkg::LED_PAGE)
			reg_sel_o = sysctl_pkg::REG_LED;
		else if (page == sysctl_pkg::RSTCTL_PAGE)
			reg_sel_o = sysctl_pkg::REG_RSTCTL;
	end
end

// strobes only in idle, so one access at a time
assign take = (state == sysctl_pkg::BUS_IDLE) && req_i;
assign wr_stb_o = take & we_i;
assign rd_stb_o = take & ~we_i;

// ------------------------------------------------------------
// access state machine
// ------------------------------------------------------------
always_comb begin
	state_nxt = state;
	case (state)
	sysctl_pkg::BUS_IDLE: begin
		if (req_i) begin
			if (reg_sel_o == sysctl_pkg::REG_NONE)
				state_nxt = sysctl_pkg::BUS_WAIT;	// nobody home
			else
				state_nxt = sysctl_pkg::BUS_ACK;
		end
	end
	sysctl_pkg::BUS_ACK:
		state_nxt = sysctl_pkg::BUS_IDLE;	// req drops on this edge
	sysctl_pkg::BUS_WAIT: begin
		if (to_cnt == TO_W'(BUS_TIMEOUT - 1))
			state_nxt = sysctl_pkg::BUS_ERR;
	end
	sysctl_pkg::BUS_ERR:
		state_nxt = sysctl_pkg::BUS_IDLE;
	default:
		state_nxt = sysctl_pkg::BUS_IDLE;
	endcase
end

always_ff @(posedge node_clk or posedge rst) begin
	if (rst) begin
		state <= sysctl_pkg::BUS_IDLE;
		to_cnt <= '0;
	end else begin
		state <= state_nxt;
		if (state == sysctl_pkg::BUS_WAIT)
			to_cnt <= to_cnt + 1'b1;
		else
			to_cnt <= '0;	// fresh count on every entry
	end
end

// responses straight from the state register
assign ack_o = state == sysctl_pkg::BUS_ACK;
assign err_o = state == sysctl_pkg::BUS_ERR;

endmodule

// ==== src/sysctl_pkg.sv ====
package sysctl_pkg;

	// ------------------------------------------------------------
	// bus and register widths
	// ------------------------------------------------------------
	localparam int ADR_W   = 32;	// bus address
	localparam int DAT_W   = 32;	// bus data
	localparam int SEL_W   = 4;	// byte lanes
	localparam int LED_W   = 8;
	localparam int RST_W   = 16;	// reset pulse vector
	localparam int CLKEN_W = 3;

	// ------------------------------------------------------------
	// address map
	// ------------------------------------------------------------
	// region compares adr[31:20], page compares adr[19:8]
	localparam logic [11:0] IO_REGION   = 12'hFD0;
	localparam logic [11:0] LED_PAGE    = 12'hFFF;
	localparam logic [11:0] RSTCTL_PAGE = 12'hFFC;

	// clock enables 2 and 1 on, 0 off
	localparam logic [CLKEN_W-1:0] CLKEN_RESET = 3'b110;

	// access machine
	typedef enum logic [1:0] {
		BUS_IDLE,	// waiting for req
		BUS_ACK,	// one-cycle ack
		BUS_WAIT,	// unmapped page timing out
		BUS_ERR	// one-cycle err
	} bus_state_e;

	// which register the address points at
	typedef enum logic [1:0] {
		REG_NONE,
		REG_LED,
		REG_RSTCTL
	} reg_sel_e;

endpackage

// ==== src/sysctl_regs.sv ====
`timescale 1ns/1ps

module sysctl_regs (
	input  logic                         node_clk,
	input  logic                         rst,
	input  sysctl_pkg::reg_sel_e         reg_sel_i,
	input  logic                         wr_stb_i,
	input  logic                         rd_stb_i,
	input  logic [sysctl_pkg::DAT_W-1:0] dat_i,
	input  logic [sysctl_pkg::DAT_W-1:0] rstctl_rdata_i,
	output logic [sysctl_pkg::DAT_W-1:0] dat_o,
	output logic [sysctl_pkg::LED_W-1:0] led_o
);

logic [sysctl_pkg::DAT_W-1:0] rd_word;	// mux output
logic rd_load;

// ------------------------------------------------------------
// LED register
// ------------------------------------------------------------
always_ff @(posedge node_clk or posedge rst) begin
	if (rst)
		led_o <= '0;
	else if (wr_stb_i && (reg_sel_i == sysctl_pkg::REG_LED))
		led_o <= dat_i[sysctl_pkg::LED_W-1:0];	// low byte only
end

// ------------------------------------------------------------
// read data
// ------------------------------------------------------------
always_comb begin
	case (reg_sel_i)
	sysctl_pkg::REG_LED:
		rd_word = {{(sysctl_pkg::DAT_W - sysctl_pkg::LED_W){1'b0}}, led_o};
	sysctl_pkg::REG_RSTCTL:
		rd_word = rstctl_rdata_i;
	default:
		rd_word = '1;	// unmapped reads as all ones
	endcase
end

// reads always load, writes only when unmapped so err returns ones
assign rd_load = rd_stb_i | (wr_stb_i & (reg_sel_i == sysctl_pkg::REG_NONE));

// captured on the accept edge, held through ack or err
always_ff @(posedge node_clk) begin
	if (rd_load)
		dat_o <= rd_word;
end

endmodule

// ==== src/sysctl_reset_ctrl.sv ====
`timescale 1ns/1ps

module sysctl_reset_ctrl #(
	parameter int RST_PULSE_CYCLES = 64
) (
	input  logic                           node_clk,
	input  logic                           rst,
	input  logic                           wr_stb_i,
	input  sysctl_pkg::reg_sel_e           reg_sel_i,
	input  logic [sysctl_pkg::SEL_W-1:0]   sel_i,
	input  logic [sysctl_pkg::DAT_W-1:0]   dat_i,
	output logic [sysctl_pkg::RST_W-1:0]   rsts_o,
	output logic [sysctl_pkg::CLKEN_W-1:0] clken_o,
	output logic [sysctl_pkg::DAT_W-1:0]   rdata_o
);

localparam int CNT_W = $clog2(RST_PULSE_CYCLES + 1);
localparam int PAD_W = sysctl_pkg::DAT_W - sysctl_pkg::CLKEN_W - sysctl_pkg::RST_W;

logic [CNT_W-1:0] pulse_cnt;	// saturates at RST_PULSE_CYCLES
logic [sysctl_pkg::RST_W-1:0] rst_reg;
logic [sysctl_pkg::CLKEN_W-1:0] clken_reg;
logic wr_hit;
logic lo_lanes;	// bytes 1..0, reset bits
logic hi_lanes;	// bytes 3..2, clock enables
logic pulse_on;

assign wr_hit = wr_stb_i && (reg_sel_i == sysctl_pkg::REG_RSTCTL);
assign lo_lanes = |sel_i[1:0];
assign hi_lanes = |sel_i[3:2];
assign pulse_on = pulse_cnt != CNT_W'(RST_PULSE_CYCLES);

// ------------------------------------------------------------
// reset register and pulse timer
// ------------------------------------------------------------
always_ff @(posedge node_clk or posedge rst) begin
	if (rst) begin
		pulse_cnt <= CNT_W'(RST_PULSE_CYCLES);	// idle = saturated
		rst_reg <= '0;
		clken_reg <= sysctl_pkg::CLKEN_RESET;
	end else begin
		if (pulse_on)
			pulse_cnt <= pulse_cnt + 1'b1;
		else
			rst_reg <= '0;	// pulse done, drop the bits

		if (wr_hit && lo_lanes) begin
			rst_reg <= dat_i[sysctl_pkg::RST_W-1:0];
			pulse_cnt <= '0;	// restart pulse
			// resetting units 5/4 also turns their clock on
			clken_reg[2] <= clken_reg[2] | (|dat_i[5:4]);
		end
		// direct load wins over the bit-2 set above
		if (wr_hit && hi_lanes)
			clken_reg <= dat_i[sysctl_pkg::RST_W +: sysctl_pkg::CLKEN_W];
	end
end

// ------------------------------------------------------------
// outputs
// ------------------------------------------------------------
assign rsts_o = pulse_on ? rst_reg : '0;	// only while counting
assign clken_o = clken_reg;
assign rdata_o = {{PAD_W{1'b0}}, clken_reg, rst_reg};	// 18..16 clken, 15..0 rst

endmodule

// ==== src/sysctl_tick_timer.sv ====
`timescale 1ns/1ps

module sysctl_tick_timer #(
	parameter int TMR_PERIOD  = 1000000,
	parameter int TMR_IRQ_ON  = 150,
	parameter int TMR_IRQ_OFF = 200
) (
	input  logic node_clk,
	input  logic rst,
	output logic tmr_irq_o
);

localparam int CNT_W = $clog2(TMR_PERIOD + 1);

logic [CNT_W-1:0] tick_cnt;	// runs 1..TMR_PERIOD

// ------------------------------------------------------------
// periodic interrupt
// ------------------------------------------------------------
// level is high for TMR_IRQ_OFF-TMR_IRQ_ON cycles per period
always_ff @(posedge node_clk or posedge rst) begin
	if (rst) begin
		tick_cnt <= CNT_W'(1);
		tmr_irq_o <= 1'b0;
	end else begin
		if (tick_cnt == CNT_W'(TMR_PERIOD))
			tick_cnt <= CNT_W'(1);	// wrap
		else
			tick_cnt <= tick_cnt + 1'b1;

		if (tick_cnt == CNT_W'(TMR_IRQ_ON))
			tmr_irq_o <= 1'b1;	// rise
		else if (tick_cnt == CNT_W'(TMR_IRQ_OFF))
			tmr_irq_o <= 1'b0;	// fall
	end
end

endmodule

// ==== src/sysctl_top.sv ====
`timescale 1ns/1ps

module sysctl_top #(
	parameter int TMR_PERIOD       = 1000000,
	parameter int TMR_IRQ_ON       = 150,
	parameter int TMR_IRQ_OFF      = 200,
	parameter int RST_PULSE_CYCLES = 64,
	parameter int BUS_TIMEOUT      = 16
) (
	input  logic                           node_clk,
	input  logic                           rst,
	// request side
	input  logic                           req_i,
	input  logic                           we_i,
	input  logic [sysctl_pkg::SEL_W-1:0]   sel_i,
	input  logic [sysctl_pkg::ADR_W-1:0]   adr_i,
	input  logic [sysctl_pkg::DAT_W-1:0]   dat_i,
	// response side
	output logic                           ack_o,
	output logic                           err_o,
	output logic [sysctl_pkg::DAT_W-1:0]   dat_o,
	// system control
	output logic [sysctl_pkg::LED_W-1:0]   led_o,
	output logic [sysctl_pkg::RST_W-1:0]   rsts_o,
	output logic [sysctl_pkg::CLKEN_W-1:0] clken_o,
	output logic                           tmr_irq_o
);

sysctl_pkg::reg_sel_e reg_sel;	// decoded target
logic wr_stb;
logic rd_stb;
logic [sysctl_pkg::DAT_W-1:0] rstctl_rdata;	// reset ctrl readback

// ------------------------------------------------------------
// bus decode and handshake
// ------------------------------------------------------------
sysctl_bus_fsm #(
	.BUS_TIMEOUT(BUS_TIMEOUT)
) u_bus_fsm (
	.node_clk  (node_clk),
	.rst       (rst),
	.req_i     (req_i),
	.we_i      (we_i),
	.adr_i     (adr_i),
	.reg_sel_o (reg_sel),
	.wr_stb_o  (wr_stb),
	.rd_stb_o  (rd_stb),
	.ack_o     (ack_o),
	.err_o     (err_o)
);

// ------------------------------------------------------------
// registers
// ------------------------------------------------------------
sysctl_regs u_regs (
	.node_clk       (node_clk),
	.rst            (rst),
	.reg_sel_i      (reg_sel),
	.wr_stb_i       (wr_stb),
	.rd_stb_i       (rd_stb),
	.dat_i          (dat_i),
	.rstctl_rdata_i (rstctl_rdata),
	.dat_o          (dat_o),
	.led_o          (led_o)
);

sysctl_reset_ctrl #(
	.RST_PULSE_CYCLES(RST_PULSE_CYCLES)
) u_reset_ctrl (
	.node_clk  (node_clk),
	.rst       (rst),
	.wr_stb_i  (wr_stb),
	.reg_sel_i (reg_sel),
	.sel_i     (sel_i),
	.dat_i     (dat_i),
	.rsts_o    (rsts_o),
	.clken_o   (clken_o),
	.rdata_o   (rstctl_rdata)
);

// free-running, no bus access
sysctl_tick_timer #(
	.TMR_PERIOD  (TMR_PERIOD),
	.TMR_IRQ_ON  (TMR_IRQ_ON),
	.TMR_IRQ_OFF (TMR_IRQ_OFF)
) u_tick_timer (
	.node_clk  (node_clk),
	.rst       (rst),
	.tmr_irq_o (tmr_irq_o)
);

endmodule

// ==== testbench/tb_sysctl.sv ====
`timescale 1ns/1ps

module tb_sysctl;

localparam int RST_PULSE_CYCLES = 64;
localparam int WAIT_LIMIT = 200;	// cycles before any wait gives up
localparam logic [31:0] LED_ADR = {sysctl_pkg::IO_REGION, sysctl_pkg::LED_PAGE, 8'h00};
localparam logic [31:0] RST_ADR = {sysctl_pkg::IO_REGION, sysctl_pkg::RSTCTL_PAGE, 8'h00};
localparam logic [31:0] OUT_ADR = 32'h1234_5600;	// outside the IO region
localparam logic [31:0] HOLE_ADR = {sysctl_pkg::IO_REGION, 12'h123, 8'h00};	// unmapped page

logic node_clk;
logic rst;
logic req_i;
logic we_i;
logic [3:0] sel_i;
logic [31:0] adr_i;
logic [31:0] dat_i;
logic ack_o;
logic err_o;
logic [31:0] dat_o;
logic [7:0] led_o;
logic [15:0] rsts_o;
logic [2:0] clken_o;
logic tmr_irq_o;

integer seed;
int cyc = 0;	// free-running cycle count
logic [7:0] m_led;	// register model
logic [15:0] m_rst;
logic [2:0] m_clken;
logic bus_busy;	// registers may move, monitor holds off
logic [15:0] resp_rsts;	// rsts_o seen in the response cycle

sysctl_top #(
	.TMR_PERIOD       (50),
	.TMR_IRQ_ON       (10),
	.TMR_IRQ_OFF      (14),
	.RST_PULSE_CYCLES (RST_PULSE_CYCLES),
	.BUS_TIMEOUT      (16)
) sysctl_top_i (
	.node_clk (node_clk), .rst (rst),
	.req_i (req_i), .we_i (we_i), .sel_i (sel_i), .adr_i (adr_i), .dat_i (dat_i),
	.ack_o (ack_o), .err_o (err_o), .dat_o (dat_o),
	.led_o (led_o), .rsts_o (rsts_o), .clken_o (clken_o), .tmr_irq_o (tmr_irq_o)
);

initial begin
	node_clk = 1'b0;
	forever #50 node_clk = ~node_clk;
end

always @(posedge node_clk) cyc <= cyc + 1;

// ------------------------------------------------------------
// reference model
// ------------------------------------------------------------
function automatic logic [31:0] expected_readback(input sysctl_pkg::reg_sel_e which);
	logic [31:0] word;
	case (which)
	sysctl_pkg::REG_LED: word = {24'h0, m_led};
	sysctl_pkg::REG_RSTCTL: word = {13'h0, m_clken, m_rst};	// clken over reset bits
	default: word = 32'hFFFF_FFFF;
	endcase
	return word;
endfunction

function automatic void model_write(input sysctl_pkg::reg_sel_e which, input logic [3:0] sel,
	input logic [31:0] data);
	if (which == sysctl_pkg::REG_LED)
		m_led = data[7:0];	// lanes ignored
	else if (which == sysctl_pkg::REG_RSTCTL) begin
		if (sel[1] | sel[0]) begin
			m_rst = data[15:0];
			if (data[5] | data[4])
				m_clken[2] = 1'b1;
		end
		if (sel[3] | sel[2])
			m_clken = data[18:16];	// upper lanes win
	end
endfunction

// ------------------------------------------------------------
// checking and bus helpers
// ------------------------------------------------------------
task automatic stop_run(input string what);
	$display("%s", what);
	$display("Simulation failed");
	$fatal(1, "stopped at first error");
endtask

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
	if (exp !== act)
		stop_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
endtask

// led and clken must match the model whenever no access is in flight
always @(negedge node_clk) begin
	if (!rst && !bus_busy) begin
		check_value("led_o monitor", {24'h0, m_led}, {24'h0, led_o});
		check_value("clken_o monitor", {29'h0, m_clken}, {29'h0, clken_o});
	end
end

task automatic bus_access(input logic we, input logic [3:0] sel, input logic [31:0] adr,
	input logic [31:0] data, output logic got_ack, output logic got_err, output logic [31:0] rdata);
	int waited;
	waited = 0;
	@(posedge node_clk);
	req_i <= 1'b1;
	we_i <= we;
	sel_i <= sel;
	adr_i <= adr;
	dat_i <= data;
	@(negedge node_clk);
	while (!ack_o && !err_o) begin
		waited++;
		if (waited == WAIT_LIMIT)
			stop_run("bus access got neither ack nor err within the wait limit");
		@(negedge node_clk);
	end
	got_ack = ack_o;
	got_err = err_o;
	rdata = dat_o;
	resp_rsts = rsts_o;
	@(posedge node_clk);
	req_i <= 1'b0;	// drop on the edge that sees the response
endtask

task automatic check_response(input string name, input sysctl_pkg::reg_sel_e which,
	input logic got_ack, input logic got_err);
	logic mapped;
	mapped = which != sysctl_pkg::REG_NONE;
	check_value({name, " ack_o"}, {31'h0, mapped}, {31'h0, got_ack});
	check_value({name, " err_o"}, {31'h0, ~mapped}, {31'h0, got_err});
endtask

task automatic write_reg(input string name, input logic [31:0] adr,
	input sysctl_pkg::reg_sel_e which, input logic [3:0] sel, input logic [31:0] data);
	logic got_ack;
	logic got_err;
	logic [31:0] rdata;
	bus_busy = 1'b1;
	bus_access(1'b1, sel, adr, data, got_ack, got_err, rdata);
	check_response(name, which, got_ack, got_err);
	if (which == sysctl_pkg::REG_NONE)
		check_value({name, " dat_o"}, 32'hFFFF_FFFF, rdata);	// err returns ones
	model_write(which, sel, data);
	bus_busy = 1'b0;
endtask

task automatic read_reg(input string name, input logic [31:0] adr,
	input sysctl_pkg::reg_sel_e which);
	logic got_ack;
	logic got_err;
	logic [31:0] rdata;
	bus_access(1'b0, 4'hF, adr, 32'h0, got_ack, got_err, rdata);
	check_response(name, which, got_ack, got_err);
	check_value({name, " dat_o"}, expected_readback(which), rdata);
endtask

task automatic wait_pulse_end();
	int waited;
	waited = 0;
	@(negedge node_clk);
	while (rsts_o != 16'h0) begin
		waited++;
		if (waited == WAIT_LIMIT)
			stop_run("rsts_o stayed set past the wait limit");
		@(negedge node_clk);
	end
	@(negedge node_clk);	// reset register clears one edge later
	m_rst = '0;
endtask

task automatic wait_irq_level(input logic level, output int at_cyc);
	int waited;
	waited = 0;
	@(negedge node_clk);
	while (tmr_irq_o !== level) begin
		waited++;
		if (waited == WAIT_LIMIT)
			stop_run("tmr_irq_o did not change within the wait limit");
		@(negedge node_clk);
	end
	at_cyc = cyc;
endtask

// ------------------------------------------------------------
// tests
// ------------------------------------------------------------
task automatic reset_pulse_check(input string name, input logic [31:0] data);
	int held;
	write_reg({name, " write"}, RST_ADR, sysctl_pkg::REG_RSTCTL, 4'b0011, data);
	check_value({name, " first cycle"}, {16'h0, data[15:0]}, {16'h0, resp_rsts});
	check_value({name, " clken_o"}, {29'h0, m_clken}, {29'h0, clken_o});
	held = 1;	// ack cycle counts as the first pulse cycle
	@(negedge node_clk);
	while (rsts_o == data[15:0]) begin
		held++;
		if (held > WAIT_LIMIT)
			stop_run("rsts_o pulse did not end");
		@(negedge node_clk);
	end
	check_value({name, " length"}, RST_PULSE_CYCLES, held);
	check_value({name, " after"}, 32'h0, {16'h0, rsts_o});
	@(negedge node_clk);
	m_rst = '0;
	read_reg({name, " readback"}, RST_ADR, sysctl_pkg::REG_RSTCTL);
endtask

task automatic clken_test();
	logic [31:0] data;
	logic [3:0] sel;
	for (int i = 0; i < 8; i++) begin
		data = $random(seed);
		sel = 4'($random(seed));
		if (i == 0) begin
			sel = 4'hF;	// both groups, direct load must win over bit 2 set
			data[5:4] = 2'b11;
			data[18] = 1'b0;
		end
		write_reg($sformatf("clken write %0d", i), RST_ADR, sysctl_pkg::REG_RSTCTL, sel, data);
		read_reg($sformatf("clken readback %0d", i), RST_ADR, sysctl_pkg::REG_RSTCTL);
		check_value($sformatf("clken_o %0d", i), {29'h0, m_clken}, {29'h0, clken_o});
		wait_pulse_end();
	end
endtask

initial begin
	logic [31:0] data;
	logic [31:0] holes [2];
	int rise_a;
	int fall_a;
	int rise_b;
	seed = 14;
	rst = 1'b1;
	req_i = 1'b0;
	we_i = 1'b0;
	sel_i = 4'h0;
	adr_i = 32'h0;
	dat_i = 32'h0;
	m_led = '0;
	m_rst = '0;
	m_clken = sysctl_pkg::CLKEN_RESET;
	bus_busy = 1'b0;
	repeat (16) @(posedge node_clk);
	rst <= 1'b0;
	@(negedge node_clk);

	// state straight out of reset
	check_value("reset led_o", 32'h0, {24'h0, led_o});
	check_value("reset rsts_o", 32'h0, {16'h0, rsts_o});
	check_value("reset clken_o", {29'h0, sysctl_pkg::CLKEN_RESET}, {29'h0, clken_o});
	check_value("reset ack_o err_o", 32'h0, {30'h0, ack_o, err_o});
	check_value("reset tmr_irq_o", 32'h0, {31'h0, tmr_irq_o});

	for (int i = 0; i < 6; i++) begin
		data = $random(seed);
		write_reg($sformatf("led write %0d", i), LED_ADR, sysctl_pkg::REG_LED,
			4'($random(seed)), data);
		check_value($sformatf("led_o %0d", i), {24'h0, data[7:0]}, {24'h0, led_o});
		read_reg($sformatf("led read %0d", i), LED_ADR, sysctl_pkg::REG_LED);
	end

	// clear clock enables first so the bit-2 set is visible
	write_reg("clken clear a", RST_ADR, sysctl_pkg::REG_RSTCTL, 4'b0100, 32'h0);
	data = $random(seed);
	data[4] = 1'b1;
	reset_pulse_check("pulse with bit 4", data);
	write_reg("clken clear b", RST_ADR, sysctl_pkg::REG_RSTCTL, 4'b1000, 32'h0);
	data = $random(seed);
	data[5:4] = 2'b00;
	data[0] = 1'b1;	// nonzero pulse
	reset_pulse_check("pulse without bits 5 4", data);

	clken_test();

	holes[0] = OUT_ADR;
	holes[1] = HOLE_ADR;
	for (int i = 0; i < 2; i++) begin
		data = $random(seed);
		write_reg($sformatf("unmapped write %0d", i), holes[i], sysctl_pkg::REG_NONE, 4'hF, data);
		read_reg($sformatf("unmapped read %0d", i), holes[i], sysctl_pkg::REG_NONE);
	end
	read_reg("led after unmapped", LED_ADR, sysctl_pkg::REG_LED);
	read_reg("rstctl after unmapped", RST_ADR, sysctl_pkg::REG_RSTCTL);

	// timer period and high time, rise to rise
	wait_irq_level(1'b0, rise_a);
	wait_irq_level(1'b1, rise_a);
	wait_irq_level(1'b0, fall_a);
	wait_irq_level(1'b1, rise_b);
	check_value("tmr_irq_o period", 50, rise_b - rise_a);
	check_value("tmr_irq_o high time", 14 - 10, fall_a - rise_a);

	$display("Simulation passed");
	$finish;
end

endmodule
